// File: Makefile
# Verilator build and run of the exec_unit testbench
# run from the project root, the testbench reads bench/exec_testdata.txt

TOP := tb_exec_unit

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -j 0 --top-module $(TOP) -f all.f

# exit status of the simulator is the test result
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: all.f
src/isa_pkg.sv
src/exec_pkg.sv
src/rf.sv
src/alu.sv
src/exec_ctrl.sv
src/exec_unit.sv
bench/tb_exec_unit.sv

// File: bench/exec_testdata.txt
// op rd rs rt imm | expected rd value zero halt, all hex, one instruction per line
// imm is 8-bit two's complement, op f is halt, op 8 is unused and runs as add
7 1 0 0 05  1 0005 0 0
7 2 0 0 fe  2 fffe 0 0
7 3 0 0 7f  3 007f 0 0
7 4 0 0 80  4 ff80 0 0
7 5 0 0 00  5 0000 1 0
6 6 1 0 fc  6 0001 0 0
6 7 2 0 03  7 0001 0 0
7 0 0 0 11  0 0011 0 0
0 5 1 2 00  5 0003 0 0
1 6 1 1 00  6 0000 1 0
1 7 6 1 00  7 fffb 0 0
2 2 7 3 00  2 007b 0 0
3 3 2 4 00  3 fffb 0 0
3 4 3 3 00  4 0000 1 0
4 1 0 1 00  1 0220 0 0
5 2 3 7 00  2 001f 0 0
4 5 2 2 00  5 8000 0 0
0 6 5 5 00  6 0000 1 0
6 6 6 0 80  6 ff80 0 0
6 6 6 0 7f  6 ffff 0 0
6 6 6 0 01  6 0000 1 0
8 0 3 1 00  0 021b 0 0
1 1 0 6 00  1 021b 0 0
5 3 1 2 00  3 0000 1 0
1 7 3 1 00  7 fde5 0 0
f 0 0 0 00  0 0000 1 1

// File: bench/tb_exec_unit.sv
////////////////////
// testbench for exec_unit with write-through and stall builds side by side
// both builds get the same program and the same expected results
// run from the project root so bench/exec_testdata.txt is found
// the last data line must be the halt
////////////////////
`timescale 1ns/10ps

module tb_exec_unit
   import isa_pkg::*;
   import exec_pkg::*;
();

   localparam int MAX_LINES = 64;
   localparam int FIELDS    = 9;
   localparam int HALT_WAIT = 20;

   logic               clk = 1'b0;
   logic               reset;
   logic         [1:0] in_valid;
   logic         [1:0] in_ready;
   instr_t       [1:0] in_instr;
   logic         [1:0] out_valid;
   logic         [1:0] out_ready;
   exec_result_t [1:0] out_result;

   logic [15:0] tdata [MAX_LINES*FIELDS];
   int          n_lines;
   int          cycles = 0;
   int          cycle_limit = 1000;
   int          next_in [2];
   int          next_out [2];
   bit          done [2];

   always #5 clk = ~clk;

   // index 0 bypasses and index 1 stalls on a dependency
   exec_unit #(.WRITE_THROUGH(1'b1)) i_exec_unit (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_valid[0]),
      .in_ready  (in_ready[0]),
      .in_instr  (in_instr[0]),
      .out_valid (out_valid[0]),
      .out_ready (out_ready[0]),
      .out_result(out_result[0])
   );

   exec_unit #(.WRITE_THROUGH(1'b0)) i_exec_unit_nb (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_valid[1]),
      .in_ready  (in_ready[1]),
      .in_instr  (in_instr[1]),
      .out_valid (out_valid[1]),
      .out_ready (out_ready[1]),
      .out_result(out_result[1])
   );

   task automatic abort_run();
      $display(">>> FAIL");
      $fatal(1, "simulation stopped on error");
   endtask

   function automatic string unit_name(input int u);
      return (u == 0) ? "write-through" : "stall";
   endfunction

   function automatic instr_t line_instr(input int i);
      instr_t ins;
      int     b;
      b       = i * FIELDS;
      ins.op  = opcode_e'(tdata[b][3:0]);
      ins.rd  = tdata[b + 1][2:0];
      ins.rs  = tdata[b + 2][2:0];
      ins.rt  = tdata[b + 3][2:0];
      ins.imm = tdata[b + 4][7:0];
      return ins;
   endfunction

   function automatic exec_result_t line_result(input int i);
      exec_result_t res;
      int           b;
      b         = i * FIELDS;
      res.rd    = tdata[b + 5][2:0];
      res.value = tdata[b + 6];
      res.zero  = tdata[b + 7][0];
      res.halt  = tdata[b + 8][0];
      return res;
   endfunction

   task automatic load_testdata();
      // the fill marks the end since op words stay within 4 bits
      for (int i = 0; i < MAX_LINES * FIELDS; i++) begin
         tdata[i] = 16'hf000 | i[15:0];
      end
      $readmemh("bench/exec_testdata.txt", tdata);
      n_lines = 0;
      while (n_lines < MAX_LINES && tdata[n_lines * FIELDS][15:12] != 4'hf) begin
         n_lines++;
      end
      if (n_lines == 0) begin
         $display("test data file is empty or could not be read");
         abort_run();
      end
      cycle_limit = 8 * n_lines + 100;
   endtask

   task automatic check_result(input exec_result_t got, input exec_result_t exp,
                               input int u, input int idx);
      if (got !== exp) begin
         $write("FAILED at %0d ns: %s unit, data line %0d: ", $time, unit_name(u), idx + 1);
         $display("got rd=%0d value=%h zero=%b halt=%b, expected rd=%0d value=%h zero=%b halt=%b",
                  got.rd, got.value, got.zero, got.halt,
                  exp.rd, exp.value, exp.zero, exp.halt);
         abort_run();
      end
   endtask

   // valid stays high and payload moves on only after a transfer
   task automatic drive_unit(input int u);
      in_valid[u] = 1'b1;
      if (next_in[u] < n_lines) begin
         in_instr[u] = line_instr(next_in[u]);
      end else begin
         // offered after the halt and never to be taken
         in_instr[u] = '{op: op_lbi, rd: 3'd7, rs: 3'd0, rt: 3'd0, imm: 8'sh42};
      end
      out_ready[u] = ($urandom % 3) != 0;
   endtask

   // transfers that the next rising edge will make
   task automatic observe_unit(input int u);
      if (in_valid[u] && in_ready[u]) begin
         next_in[u]++;
      end
      if (out_valid[u] && out_ready[u]) begin
         if (next_out[u] >= n_lines) begin
            $display("%s unit gave a result past the end of the test data", unit_name(u));
            abort_run();
         end
         check_result(out_result[u], line_result(next_out[u]), u, next_out[u]);
         if (out_result[u].halt) begin
            done[u] = 1'b1;
         end
         next_out[u]++;
      end
   endtask

   task automatic check_halted(input bit u);
      repeat (HALT_WAIT) begin
         drive_unit(0);
         drive_unit(1);
         #1;
         if (in_ready[u] || out_valid[u]) begin
            $display("%s unit took or gave data after its halt", unit_name(int'(u)));
            abort_run();
         end
         @(negedge clk);
      end
   endtask

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("timeout after %0d cycles, the run did not complete", cycles);
         abort_run();
      end
   end

   initial begin
      void'($urandom(32'h49664b39));
      reset     = 1'b1;
      in_valid  = '0;
      in_instr  = '0;
      out_ready = '0;
      for (int u = 0; u < 2; u++) begin
         next_in[u]  = 0;
         next_out[u] = 0;
         done[u]     = 1'b0;
      end
      load_testdata();
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      while (!(done[0] && done[1])) begin
         drive_unit(0);
         drive_unit(1);
         #1;
         observe_unit(0);
         observe_unit(1);
         @(negedge clk);
      end

      check_halted(1'b0);
      check_halted(1'b1);

      if (next_in[0] != n_lines || next_in[1] != n_lines) begin
         $display("an instruction was accepted after the halt");
         abort_run();
      end else begin
         $display(">>> PASS");
         $finish;
      end
   end

endmodule

// File: src/alu.sv
////////////////////
// 16-bit ALU, wrap-around arithmetic
// shifts use b[3:0], immediates are sign-extended
////////////////////
`timescale 1ns/10ps

module alu
   import isa_pkg::*;
(
   input  opcode_e           op,
   input  word_t             a,
   input  word_t             b,
   input  logic signed [7:0] imm,
   output word_t             value,
   output logic              zero
);

   word_t    imm_ext;
   logic [3:0] shamt;

   assign imm_ext = {{8{imm[7]}}, imm};
   assign shamt   = b[3:0];

   always_comb begin
      case (op)
         op_add: begin
            value = a + b;
         end
         op_sub: begin
            value = a - b;
         end
         op_and: begin
            value = a & b;
         end
         op_xor: begin
            value = a ^ b;
         end
         op_sll: begin
            value = a << shamt;
         end
         op_srl: begin
            // logical, zeros shifted in
            value = a >> shamt;
         end
         op_addi: begin
            value = a + imm_ext;
         end
         op_lbi: begin
            value = imm_ext;
         end
         default: begin
            // halt and unused codes fall back to add
            value = a + b;
         end
      endcase
   end

   assign zero = (value == '0);

endmodule

// File: src/exec_ctrl.sv
////////////////////
// stage-2 register, hazard stall, write commit, halt
// registers change only when their result is taken
// after halt, no intake until reset
////////////////////
`timescale 1ns/10ps

module exec_ctrl
   import isa_pkg::*;
   import exec_pkg::*;
#(
   parameter bit WRITE_THROUGH = 1'b1
) (
   input  logic         clk,
   input  logic         reset,
   input  logic         in_valid,
   output logic         in_ready,
   input  instr_t       in_instr,
   input  word_t        rs_data,
   input  word_t        rt_data,
   output instr_t       ex_instr,
   output word_t        ex_a,
   output word_t        ex_b,
   input  word_t        alu_value,
   input  logic         alu_zero,
   output logic         out_valid,
   input  logic         out_ready,
   output exec_result_t out_result,
   output logic         wr_en,
   output reg_sel_t     wr_sel,
   output word_t        wr_data
);

   ctrl_state_e state;
   logic        ex_valid;
   logic        run_en;
   logic        ex_is_halt;
   logic        ex_writes;
   logic        out_fire;
   logic        hazard;
   logic        accept;

   assign ex_is_halt = (ex_instr.op == op_halt);
   assign ex_writes  = ex_valid && !ex_is_halt;
   assign out_fire   = out_valid && out_ready;

   // stage 2 result not yet usable by the incoming read
   assign hazard = ex_writes
                   && (ex_instr.rd == in_instr.rs || ex_instr.rd == in_instr.rt)
                   && (!out_ready || !WRITE_THROUGH);

   assign in_ready = run_en && (state == st_run) && (!ex_valid || out_ready) && !hazard;
   assign accept   = in_valid && in_ready;

   // intake opens the cycle after reset is released
   always_ff @(posedge clk) begin
      if (reset) begin
         run_en <= 1'b0;
      end else begin
         run_en <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ex_valid <= 1'b0;
      end else if (accept) begin
         ex_valid <= 1'b1;
      end else if (out_fire) begin
         ex_valid <= 1'b0;
      end
   end

   // payload and its operands load on acceptance
   always_ff @(posedge clk) begin
      if (accept) begin
         ex_instr <= in_instr;
         ex_a     <= rs_data;
         ex_b     <= rt_data;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= st_run;
      end else begin
         case (state)
            st_run: begin
               if (accept && in_instr.op == op_halt) begin
                  state <= st_drain;
               end
            end
            st_drain: begin
               // halt is the only item left in stage 2
               if (out_fire) begin
                  state <= st_halted;
               end
            end
            default: begin
               state <= st_halted;
            end
         endcase
      end
   end

   assign out_valid = ex_valid;

   always_comb begin
      if (ex_is_halt) begin
         out_result = '{rd: '0, value: '0, zero: 1'b1, halt: 1'b1};
      end else begin
         out_result = '{rd: ex_instr.rd, value: alu_value, zero: alu_zero, halt: 1'b0};
      end
   end

   // commit on the output handshake
   assign wr_en   = out_fire && !ex_is_halt;
   assign wr_sel  = ex_instr.rd;
   assign wr_data = alu_value;

   assert property (@(posedge clk) disable iff (reset)
      out_valid && !out_ready |=> out_valid && $stable(out_result));

   // stage 2 stays empty once halted
   assert property (@(posedge clk) disable iff (reset)
      state == st_halted |-> !in_ready && !out_valid);

endmodule

// File: src/exec_pkg.sv
////////////////////
// pipeline control and result types
// a halt result has rd 0, value 0, zero 1, halt 1
////////////////////

package exec_pkg;

   import isa_pkg::*;

   // control state machine
   typedef enum logic [1:0] {
      st_run    = 2'd0,
      st_drain  = 2'd1,
      st_halted = 2'd2
   } ctrl_state_e;

   // record on the result stream
   typedef struct packed {
      reg_sel_t rd;
      word_t    value;
      logic     zero;
      logic     halt;
   } exec_result_t;

endpackage

// File: src/exec_unit.sv
////////////////////
// two-stage register read and execute unit
// valid/ready streams in and out, one result per cycle
// WRITE_THROUGH=0 stalls on a same-cycle dependency
////////////////////
`timescale 1ns/10ps

module exec_unit
   import isa_pkg::*;
   import exec_pkg::*;
#(
   parameter bit WRITE_THROUGH = 1'b1
) (
   input  logic         clk,
   input  logic         reset,
   input  logic         in_valid,
   output logic         in_ready,
   input  instr_t       in_instr,
   output logic         out_valid,
   input  logic         out_ready,
   output exec_result_t out_result
);

   word_t    rs_data;
   word_t    rt_data;
   instr_t   ex_instr;
   word_t    ex_a;
   word_t    ex_b;
   word_t    alu_value;
   logic     alu_zero;
   logic     wr_en;
   reg_sel_t wr_sel;
   word_t    wr_data;

   exec_ctrl #(
      .WRITE_THROUGH(WRITE_THROUGH)
   ) i_exec_ctrl (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_instr  (in_instr),
      .rs_data   (rs_data),
      .rt_data   (rt_data),
      .ex_instr  (ex_instr),
      .ex_a      (ex_a),
      .ex_b      (ex_b),
      .alu_value (alu_value),
      .alu_zero  (alu_zero),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_result(out_result),
      .wr_en     (wr_en),
      .wr_sel    (wr_sel),
      .wr_data   (wr_data)
   );

   // stage 1 read straight from the incoming instruction
   rf #(
      .WRITE_THROUGH(WRITE_THROUGH)
   ) i_rf (
      .clk     (clk),
      .reset   (reset),
      .rd_sel1 (in_instr.rs),
      .rd_sel2 (in_instr.rt),
      .rd_data1(rs_data),
      .rd_data2(rt_data),
      .wr_en   (wr_en),
      .wr_sel  (wr_sel),
      .wr_data (wr_data)
   );

   alu i_alu (
      .op   (ex_instr.op),
      .a    (ex_a),
      .b    (ex_b),
      .imm  (ex_instr.imm),
      .value(alu_value),
      .zero (alu_zero)
   );

endmodule

// File: src/isa_pkg.sv
////////////////////
// instruction set of the execute subsystem
// 16-bit data, eight registers, 21-bit instruction word
// unknown opcodes execute as op_add
////////////////////

package isa_pkg;

   // register number and data word
   typedef logic [2:0]  reg_sel_t;
   typedef logic [15:0] word_t;

   // operation codes, 4 bits
   typedef enum logic [3:0] {
      op_add  = 4'd0,
      op_sub  = 4'd1,
      op_and  = 4'd2,
      op_xor  = 4'd3,
      op_sll  = 4'd4,
      op_srl  = 4'd5,
      op_addi = 4'd6,
      op_lbi  = 4'd7,
      op_halt = 4'd15
   } opcode_e;

   // one instruction as it arrives on the input stream
   typedef struct packed {
      opcode_e          op;
      reg_sel_t         rd;
      reg_sel_t         rs;
      reg_sel_t         rt;
      logic signed [7:0] imm;
   } instr_t;

endpackage

// File: src/rf.sv
////////////////////
// eight 16-bit registers, two async reads, one write
// WRITE_THROUGH=1 forwards same-cycle write data to reads
// all registers clear on reset
////////////////////
`timescale 1ns/10ps

module rf
   import isa_pkg::*;
#(
   parameter bit WRITE_THROUGH = 1'b1
) (
   input  logic     clk,
   input  logic     reset,
   input  reg_sel_t rd_sel1,
   input  reg_sel_t rd_sel2,
   output word_t    rd_data1,
   output word_t    rd_data2,
   input  logic     wr_en,
   input  reg_sel_t wr_sel,
   input  word_t    wr_data
);

   word_t regs [8];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_sel] <= wr_data;
      end
   end

   // read ports, with optional bypass of the write in progress
   always_comb begin
      rd_data1 = regs[rd_sel1];
      rd_data2 = regs[rd_sel2];
      if (WRITE_THROUGH && wr_en) begin
         if (wr_sel == rd_sel1) begin
            rd_data1 = wr_data;
         end
         if (wr_sel == rd_sel2) begin
            rd_data2 = wr_data;
         end
      end
   end

   // a write must name a known register
   assert property (@(posedge clk) disable iff (reset)
      wr_en |-> !$isunknown(wr_sel));

endmodule
